// ==== Bender.yml ====
package:
  name: uart_top

export_include_dirs:
  - .

sources:
  - uart_pkg.sv
  - uart_fifo.sv
  - uart_baud_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_tx_queue.sv
  - uart_axil_regs.sv
  - uart_top.sv
  - target: test
    files:
      - tb_uart_top.sv

// ==== tb_uart_top.sv ====
`default_nettype none

`include "uart_consts.svh"

module tb_uart_top import uart_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BIT_CLKS    = 4 * `UART_BAUD_DIV4; // clocks per serial bit
	localparam int FRAME_CLKS  = 10 * BIT_CLKS;
	localparam int HS_LIMIT    = 100;  // cycles allowed for one AXI handshake
	localparam int POLL_LIMIT  = 400;  // STATUS polls before giving up
	localparam int RX_LIMIT    = 6000; // cycles allowed for a burst of frames

	logic     clk;
	logic     reset;
	axil_aw_t aw;
	logic     aw_valid;
	logic     aw_ready;
	axil_w_t  w;
	logic     w_valid;
	logic     w_ready;
	axil_b_t  b;
	logic     b_valid;
	logic     b_ready;
	axil_ar_t ar;
	logic     ar_valid;
	logic     ar_ready;
	axil_r_t  r;
	logic     r_valid;
	logic     r_ready;
	logic     serial_out;
	logic     serial_in;
	logic     loopback;  // 1 routes serial_out back into the receiver
	logic     drv_line;  // line from the testbench bit driver

	logic [1:0]  exp_b_resp;
	logic        b_chk;      // compare the write response
	logic [1:0]  exp_r_resp;
	logic [31:0] exp_r_data;
	logic [31:0] exp_r_mask; // only masked read bits are compared
	logic [7:0]  sent_q [$]; // bytes expected back, oldest first
	int          errors;
	int          checks;
	int          rx_count;   // receiver strobes seen so far
	int          seed;

	uart_top dut (.*);

	assign serial_in = loopback ? serial_out : drv_line;

	always #20 clk = ~clk;

	// counted mid cycle, rx_valid is one clock wide
	always @(negedge clk) begin
		if (dut.u_rx.rx_valid)
			rx_count <= rx_count + 1;
	end

	a_idle_line: assert property (@(posedge clk) $fell(reset) |-> serial_out)
		else begin
			errors++;
			$display("Fail %0t: serial_out not idle high after reset", $time);
		end

	// address and data channels are taken in the same cycle
	a_aw_w_pair: assert property (@(posedge clk) disable iff (reset) aw_ready == w_ready)
		else begin
			errors++;
			$display("Fail %0t: aw_ready %b and w_ready %b differ", $time,
				$sampled(aw_ready), $sampled(w_ready));
		end

	a_b_resp: assert property (@(posedge clk) disable iff (reset)
		b_valid && b_ready && b_chk |-> b.resp == exp_b_resp)
		else begin
			errors++;
			$display("Fail %0t: write resp %0d, expected %0d", $time, $sampled(b.resp),
				exp_b_resp);
		end

	a_r_resp: assert property (@(posedge clk) disable iff (reset)
		r_valid && r_ready |-> r.resp == exp_r_resp && (r.data & exp_r_mask) == exp_r_data)
		else begin
			errors++;
			$display("Fail %0t: read data %h resp %0d, expected %h resp %0d (mask %h)",
				$time, $sampled(r.data), $sampled(r.resp), exp_r_data, exp_r_resp, exp_r_mask);
		end

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			input logic [1:0] resp_exp, input logic chk, output logic [1:0] resp);
		int n;
		@(posedge clk);
		#2;
		aw.addr    = addr;
		w.data     = data;
		aw_valid   = 1'b1;
		w_valid    = 1'b1;
		b_ready    = 1'b1;
		exp_b_resp = resp_exp;
		b_chk      = chk;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!aw_ready && n < HS_LIMIT);
		if (!aw_ready)
			abort_run("write address was never accepted");
		@(posedge clk); // handshake edge
		#2;
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!b_valid && n < HS_LIMIT);
		if (!b_valid)
			abort_run("write response never came");
		resp = b.resp;
		if (chk)
			checks++;
		@(posedge clk); // response taken here, b_ready already high
		#2;
		b_ready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, input logic [1:0] resp_exp,
			input logic [31:0] data_exp, input logic [31:0] mask, output logic [31:0] data);
		int n;
		@(posedge clk);
		#2;
		ar.addr    = addr;
		ar_valid   = 1'b1;
		r_ready    = 1'b1;
		exp_r_resp = resp_exp;
		exp_r_data = data_exp;
		exp_r_mask = mask;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ar_ready && n < HS_LIMIT);
		if (!ar_ready)
			abort_run("read address was never accepted");
		@(posedge clk);
		#2;
		ar_valid = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!r_valid && n < HS_LIMIT);
		if (!r_valid)
			abort_run("read response never came");
		data = r.data;
		checks++;
		@(posedge clk);
		#2;
		r_ready = 1'b0;
	endtask

	// queue one byte for transmission and remember it for the receive side
	task automatic send_byte(input logic [7:0] data);
		logic [1:0] resp;
		write_reg(`UART_REG_TXDATA, {24'b0, data}, `UART_RESP_OKAY, 1'b1, resp);
		sent_q.push_back(data);
	endtask

	// poll STATUS until data is there, then pop it; overrun must stay clear while polling
	task automatic expect_rx(input logic [8:0] entry_exp);
		logic [31:0] st;
		int n;
		n = 0;
		do begin
			read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h0, 32'hffff_fffc, st);
			n++;
		end while (!st[1] && n < POLL_LIMIT);
		if (!st[1])
			abort_run("no received byte showed up in STATUS");
		read_reg(`UART_REG_RXDATA, `UART_RESP_OKAY, {23'b0, entry_exp}, '1, st);
	endtask

	task automatic wait_rx_strobes(input int target);
		int n;
		n = 0;
		while (rx_count < target && n < RX_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (rx_count < target)
			abort_run("receiver did not deliver the expected frames");
	endtask

	// start, eight data bits lsb first, then the stop bit
	task automatic drive_frame(input logic [7:0] data, input logic stop_ok);
		logic [8:0] bits;
		bits = {data, 1'b0};
		for (int i = 0; i < 9; i++) begin
			@(posedge clk);
			#2 drv_line = bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		#2 drv_line = stop_ok;
		// a bad stop bit is cut short, a full low bit would read as the next start edge
		repeat (stop_ok ? BIT_CLKS - 1 : 9) @(posedge clk);
		#2 drv_line = 1'b1;
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	initial begin
		logic [1:0]  resp;
		logic [31:0] data;
		logic [7:0]  rnd;
		int          rejected;
		int          base;
		clk        = 1'b0;
		reset      = 1'b1;
		aw         = '0;
		aw_valid   = 1'b0;
		w          = '0;
		w_valid    = 1'b0;
		b_ready    = 1'b0;
		ar         = '0;
		ar_valid   = 1'b0;
		r_ready    = 1'b0;
		loopback   = 1'b1;
		drv_line   = 1'b1;
		b_chk      = 1'b1;
		exp_b_resp = `UART_RESP_OKAY;
		exp_r_resp = `UART_RESP_OKAY;
		exp_r_data = '0;
		exp_r_mask = '0;
		errors     = 0;
		checks     = 0;
		rx_count   = 0;
		rejected   = 0;
		seed       = 32'h2c6b_ac46;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;

		// idle: space only
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h1, '1, data);

		// plain loopback, four bytes
		for (int i = 0; i < 4; i++) begin
			rnd = 8'($random(seed));
			send_byte(rnd);
		end
		while (sent_q.size() > 0)
			expect_rx({1'b0, sent_q.pop_front()});

		// flood the tx queue, refused bytes must never reach the line
		for (int i = 0; i < `UART_TX_DEPTH + 2; i++) begin
			rnd = 8'($random(seed));
			write_reg(`UART_REG_TXDATA, {24'b0, rnd}, `UART_RESP_OKAY, 1'b0, resp);
			if (resp == `UART_RESP_OKAY)
				sent_q.push_back(rnd);
			else
				rejected++;
		end
		assert (rejected > 0)
		else begin
			errors++;
			$display("Fail %0t: no SLVERR with a full transmit queue", $time);
		end
		while (sent_q.size() > 0)
			expect_rx({1'b0, sent_q.pop_front()});
		idle_cycles(2 * FRAME_CLKS);
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h1, '1, data);

		// one byte more than the rx queue holds
		base = rx_count;
		for (int i = 0; i < `UART_RX_DEPTH + 1; i++) begin
			rnd = 8'($random(seed));
			send_byte(rnd);
		end
		wait_rx_strobes(base + `UART_RX_DEPTH + 1);
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h7, '1, data);
		for (int i = 0; i < `UART_RX_DEPTH; i++)
			read_reg(`UART_REG_RXDATA, `UART_RESP_OKAY, {24'b0, sent_q.pop_front()}, '1, data);
		void'(sent_q.pop_front()); // the dropped byte
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h1, '1, data);
		rnd = 8'($random(seed));
		send_byte(rnd);
		expect_rx({1'b1, sent_q.pop_front()});

		// framing error then a good frame, both from the bit driver
		loopback = 1'b0;
		drive_frame(8'ha5, 1'b0);
		idle_cycles(3 * BIT_CLKS);
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h1, '1, data);
		rnd = 8'($random(seed));
		drive_frame(rnd, 1'b1);
		expect_rx({1'b0, rnd});

		// error responses
		read_reg(`UART_REG_RXDATA, `UART_RESP_SLVERR, 32'h0, '1, data);
		write_reg(`UART_REG_STATUS, 32'h7, `UART_RESP_SLVERR, 1'b1, resp);
		read_reg(4'hc, `UART_RESP_SLVERR, 32'h0, '1, data);
		write_reg(4'hc, 32'h5a, `UART_RESP_SLVERR, 1'b1, resp);
		read_reg(`UART_REG_STATUS, `UART_RESP_OKAY, 32'h1, '1, data); // nothing changed

		idle_cycles(4);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_axil_regs.sv ====
`default_nettype none

`include "uart_consts.svh"

module uart_axil_regs import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  axil_aw_t   aw,
	input  logic       aw_valid,
	output logic       aw_ready,
	input  axil_w_t    w,
	input  logic       w_valid,
	output logic       w_ready,
	output axil_b_t    b,
	output logic       b_valid,
	input  logic       b_ready,
	input  axil_ar_t   ar,
	input  logic       ar_valid,
	output logic       ar_ready,
	output axil_r_t    r,
	output logic       r_valid,
	input  logic       r_ready,
	output uart_byte_t tx_data,
	output logic       tx_push,
	input  logic       tx_space,
	input  uart_byte_t rx_data,
	input  logic       rx_valid
);
	logic           wr_accept;
	logic           rd_accept;
	logic           wr_tx;        // write aimed at TXDATA
	logic           rd_rx;        // accepted read of RXDATA
	logic           rd_status;    // accepted read of STATUS
	logic           rx_store;
	logic           rx_drop;
	logic           rx_not_empty;
	logic           rx_not_full;
	logic           overrun_q;    // sticky, cleared by a STATUS read
	logic           mark_q;       // next stored byte gets after_overrun
	uart_rx_entry_t rx_entry;
	uart_rx_entry_t rx_head;

	// one outstanding transaction per direction, a held response blocks its channel
	assign wr_accept = aw_valid && w_valid && !b_valid;
	assign aw_ready  = wr_accept;
	assign w_ready   = wr_accept;
	assign wr_tx     = (aw.addr == `UART_REG_TXDATA);
	assign tx_push   = wr_accept && wr_tx && tx_space; // full queue drops the byte
	assign tx_data   = w.data[7:0];

	assign rd_accept = ar_valid && !r_valid;
	assign ar_ready  = rd_accept;
	assign rd_rx     = rd_accept && (ar.addr == `UART_REG_RXDATA);
	assign rd_status = rd_accept && (ar.addr == `UART_REG_STATUS);

	// no back-pressure toward the receiver
	assign rx_store = rx_valid && rx_not_full;
	assign rx_drop  = rx_valid && !rx_not_full;
	assign rx_entry = '{after_overrun: mark_q, data: rx_data};

	uart_fifo #(
		.payload_t (uart_rx_entry_t),
		.DEPTH     (`UART_RX_DEPTH)
	) u_rx_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (rx_store),
		.push_data (rx_entry),
		.pop       (rd_rx && rx_not_empty), // pop in the accept cycle
		.pop_data  (rx_head),
		.not_empty (rx_not_empty),
		.not_full  (rx_not_full)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			b_valid   <= 1'b0;
			r_valid   <= 1'b0;
			overrun_q <= 1'b0;
			mark_q    <= 1'b0;
		end else begin
			if (wr_accept)
				b_valid <= 1'b1;
			else if (b_ready)
				b_valid <= 1'b0;
			if (rd_accept)
				r_valid <= 1'b1;
			else if (r_ready)
				r_valid <= 1'b0;
			// a fresh drop wins over a clearing read in the same cycle
			if (rx_drop)
				overrun_q <= 1'b1;
			else if (rd_status)
				overrun_q <= 1'b0;
			if (rx_drop)
				mark_q <= 1'b1;
			else if (rx_store)
				mark_q <= 1'b0;
		end
	end

	// response payloads, captured on the handshake
	always_ff @(posedge clk) begin
		if (wr_accept)
			b.resp <= (wr_tx && tx_space) ? `UART_RESP_OKAY : `UART_RESP_SLVERR;
		if (rd_accept) begin
			r.data <= '0; // errors return zero
			r.resp <= `UART_RESP_SLVERR;
			if (rd_rx && rx_not_empty) begin
				r.data <= {23'b0, rx_head}; // after_overrun lands in bit 8
				r.resp <= `UART_RESP_OKAY;
			end else if (rd_status) begin
				r.data <= {29'b0, overrun_q, rx_not_empty, tx_space};
				r.resp <= `UART_RESP_OKAY;
			end
		end
	end

endmodule

`default_nettype wire

// ==== uart_baud_gen.sv ====
`default_nettype none

`include "uart_consts.svh"

module uart_baud_gen (
	input  logic clk,
	input  logic reset,
	output logic baud_x4, // one clock every UART_BAUD_DIV4 clocks
	output logic baud_x1  // every fourth baud_x4, marks a bit boundary
);
	localparam int CNT_W = ($clog2(`UART_BAUD_DIV4) > 0) ? $clog2(`UART_BAUD_DIV4) : 1;

	logic [CNT_W-1:0] div_q;   // clock divider
	logic [1:0]       phase_q; // counts x4 strobes within one bit
	logic             wrap;

	assign wrap = (div_q == CNT_W'(`UART_BAUD_DIV4 - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			div_q   <= '0;
			phase_q <= '0;
			baud_x4 <= 1'b0;
			baud_x1 <= 1'b0;
		end else begin
			div_q   <= wrap ? '0 : div_q + 1'b1;
			baud_x4 <= wrap;
			baud_x1 <= wrap && (phase_q == 2'd3); // registered so it lines up with baud_x4
			if (wrap)
				phase_q <= phase_q + 1'b1;
		end
	end

	// the transmitter and receiver assume the bit strobe is always also an x4 strobe
	a_x1_in_x4: assert property (@(posedge clk) disable iff (reset) baud_x1 |-> baud_x4);

endmodule

`default_nettype wire

// ==== uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clocks per baud_x4 strobe, one bit is four strobes
`define UART_BAUD_DIV4 4

// queue depths in entries
`define UART_TX_DEPTH 8
`define UART_RX_DEPTH 4

// register byte offsets in the 4-bit address space
`define UART_REG_TXDATA 4'h0
`define UART_REG_RXDATA 4'h4
`define UART_REG_STATUS 4'h8

// axi response codes
`define UART_RESP_OKAY   2'b00
`define UART_RESP_SLVERR 2'b10

`endif

// ==== uart_fifo.sv ====
`default_nettype none

module uart_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,   // head entry, valid while not_empty
	output logic     not_empty,
	output logic     not_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	// wraps at DEPTH so the depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign pop_data  = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign not_full  = (count != CNT_W'(DEPTH));

	// callers gate on the flags, these catch a caller that does not
	a_no_overflow:  assert property (@(posedge clk) disable iff (reset) push |-> not_full);
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> not_empty);

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	typedef logic [7:0] uart_byte_t; // one data byte on the line

	// receive queue entry; after_overrun sits in bit 8 of the packed value
	typedef struct packed {
		logic       after_overrun; // first byte kept after a dropped one
		uart_byte_t data;
	} uart_rx_entry_t;

	typedef struct packed {
		logic [3:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [3:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data; // only the low byte is used, no strobes
	} axil_w_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       baud_x4,
	input  logic       serial,   // asynchronous line
	output uart_byte_t rx_data,
	output logic       rx_valid  // one clock per good frame
);
	logic [1:0] sync_q;   // two-flop synchronizer
	logic       serial_s;
	logic [5:0] state_q;  // bit count in 5:2, phase in 1:0
	logic [3:0] bit_count;
	logic [1:0] bit_phase;
	logic       sample;
	logic       start_bit;
	logic       stop_bit;
	logic       idle;
	logic       framing_err;
	logic [8:0] shift_q;  // data bits plus the stop bit at the top

	assign serial_s  = sync_q[1];
	assign bit_count = state_q[5:2];
	assign bit_phase = state_q[1:0];

	// phase 1 lands near the middle of the bit, the edge was seen at phase 0
	assign sample      = (bit_phase == 2'd1);
	assign start_bit   = sample && (bit_count == 4'd0);
	assign stop_bit    = sample && (bit_count == 4'd9);
	assign idle        = (state_q == '0) && serial_s;
	assign framing_err = (start_bit && serial_s) || (stop_bit && !serial_s);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_q <= 2'b11; // line idles high
		end else begin
			sync_q <= {sync_q[0], serial};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (baud_x4) begin
				// a glitch start or a low stop bit both go back to hunting
				if (idle || framing_err || stop_bit)
					state_q <= '0;
				else
					state_q <= state_q + 1'b1;
				rx_valid <= stop_bit && !framing_err; // bad frames vanish
			end
		end
	end

	// start, eight data and stop samples all pass through, lsb first
	always_ff @(posedge clk) begin
		if (baud_x4 && sample)
			shift_q <= {serial_s, shift_q[8:1]};
	end

	assign rx_data = shift_q[7:0];

	// the register block pushes on every strobe clock, a wide strobe would store twice
	a_valid_pulse: assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== uart_top.f ====
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_tx_queue.sv
uart_axil_regs.sv
uart_top.sv
tb_uart_top.sv

// ==== uart_top.sv ====
`default_nettype none

module uart_top import uart_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  axil_aw_t aw,
	input  logic     aw_valid,
	output logic     aw_ready,
	input  axil_w_t  w,
	input  logic     w_valid,
	output logic     w_ready,
	output axil_b_t  b,
	output logic     b_valid,
	input  logic     b_ready,
	input  axil_ar_t ar,
	input  logic     ar_valid,
	output logic     ar_ready,
	output axil_r_t  r,
	output logic     r_valid,
	input  logic     r_ready,
	output logic     serial_out,
	input  logic     serial_in
);
	uart_byte_t tx_data;
	uart_byte_t rx_data;
	logic       tx_push;
	logic       tx_space;
	logic       rx_valid;
	logic       baud_x4;
	logic       baud_x1;

	uart_axil_regs u_regs (
		.clk, .reset,
		.aw, .aw_valid, .aw_ready,
		.w, .w_valid, .w_ready,
		.b, .b_valid, .b_ready,
		.ar, .ar_valid, .ar_ready,
		.r, .r_valid, .r_ready,
		.tx_data, .tx_push, .tx_space,
		.rx_data, .rx_valid
	);

	uart_baud_gen u_baud (.clk, .reset, .baud_x4, .baud_x1);

	uart_tx_queue u_tx_queue (
		.clk, .reset, .baud_x1,
		.tx_data, .tx_push, .tx_space,
		.serial (serial_out)
	);

	uart_rx u_rx (.clk, .reset, .baud_x4, .serial (serial_in), .rx_data, .rx_valid);

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       baud_x1,
	input  uart_byte_t data,
	input  logic       load,   // one clock, only while ready
	output logic       ready,
	output logic       serial
);
	// {stop, data, start}, shifted out lsb first
	// the stop bit marks the register as busy, so all zero means empty
	logic [9:0] shift_q;
	logic       serial_n_q; // line is stored inverted so reset gives idle high

	assign serial = ~serial_n_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shift_q    <= '0;
			serial_n_q <= 1'b0;
			ready      <= 1'b1;
		end else if (load) begin
			shift_q <= {1'b1, data, 1'b0};
			ready   <= 1'b0; // drops the cycle after load
		end else if (baud_x1) begin
			if (shift_q == '0) begin
				serial_n_q <= 1'b0; // back to idle once the stop bit has run its period
				ready      <= 1'b1;
			end else begin
				serial_n_q <= ~shift_q[0];
			end
			shift_q <= {1'b0, shift_q[9:1]};
		end
	end

	// the drain logic in the queue must wait for ready, a load mid frame corrupts it
	a_load_ready: assert property (@(posedge clk) disable iff (reset) load |-> ready);

endmodule

`default_nettype wire

// ==== uart_tx_queue.sv ====
`default_nettype none

`include "uart_consts.svh"

module uart_tx_queue import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       baud_x1,
	input  uart_byte_t tx_data,
	input  logic       tx_push,  // one clock, only with tx_space
	output logic       tx_space,
	output logic       serial
);
	uart_byte_t head;
	logic       queued;    // queue has a byte waiting
	logic       tx_ready;
	logic       load_q;    // pops the queue and loads the transmitter together

	uart_fifo #(
		.payload_t (uart_byte_t),
		.DEPTH     (`UART_TX_DEPTH)
	) u_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (tx_push),
		.push_data (tx_data),
		.pop       (load_q),
		.pop_data  (head),
		.not_empty (queued),
		.not_full  (tx_space)
	);

	// ready only falls the cycle after a load, so skip the cycle following one
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			load_q <= 1'b0;
		else
			load_q <= queued && tx_ready && !load_q;
	end

	uart_tx u_tx (
		.clk     (clk),
		.reset   (reset),
		.baud_x1 (baud_x1),
		.data    (head),    // head stays put until the pop
		.load    (load_q),
		.ready   (tx_ready),
		.serial  (serial)
	);

endmodule

`default_nettype wire
